/* run_sim.sh */
#!/bin/sh
# compile and run the bpu testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module bpu_tb -f sim.f -o bpu_sim

out=$(./obj_dir/bpu_sim)
echo "$out"

if echo "$out" | grep -q "STATUS: PASS"; then
    exit 0
fi
exit 1

/* sim.f */
+incdir+source
source/bpu_pkg.sv
source/bpu_if.sv
source/bpu_ctrl.sv
source/tage_tables.sv
source/btb.sv
source/ras.sv
source/bpu.sv
tests/tb_clock.sv
tests/bpu_tb.sv

/* source/bpu.sv */
`timescale 1ns/1ns

module bpu (
    input  logic               clk,
    input  logic               rst,
    input  bpu_pkg::addr_t     if_pc_i,
    input  bpu_pkg::inst_t     if_inst_i,
    input  logic               ex_branch_valid_i,
    input  logic               ex_branch_taken_i,
    input  logic               ex_pdt_true_i,
    input  bpu_pkg::addr_t     ex_pc_i,
    input  bpu_pkg::ghist_t    ex_history_i,
    input  bpu_pkg::provider_t ex_provider_i,
    input  bpu_pkg::addr_t     ex_target_i,
    input  bpu_pkg::inst_t     ex_inst_i,
    input  logic               id_ras_push_valid_i,
    input  bpu_pkg::addr_t     id_ras_push_data_i,
    input  logic               ex_stall_valid_i,
    output logic               branch_or_not_o,
    output logic               pdt_res_o,
    output bpu_pkg::addr_t     pdt_pc_o,
    output bpu_pkg::ghist_t    history_o,
    output bpu_pkg::provider_t provider_o
);

    lookup_if lk ();
    update_if upd ();

    logic           btb_hit;
    bpu_pkg::addr_t btb_target;
    bpu_pkg::addr_t ras_top;
    logic           ras_valid;
    logic           ras_push;
    logic           ras_pop;
    bpu_pkg::addr_t ras_push_data;

    bpu_ctrl ctrl_i (
        .clk                 (clk),
        .rst                 (rst),
        .if_pc_i             (if_pc_i),
        .if_inst_i           (if_inst_i),
        .ex_branch_valid_i   (ex_branch_valid_i),
        .ex_branch_taken_i   (ex_branch_taken_i),
        .ex_pdt_true_i       (ex_pdt_true_i),
        .ex_pc_i             (ex_pc_i),
        .ex_history_i        (ex_history_i),
        .ex_provider_i       (ex_provider_i),
        .ex_target_i         (ex_target_i),
        .ex_inst_i           (ex_inst_i),
        .id_ras_push_valid_i (id_ras_push_valid_i),
        .id_ras_push_data_i  (id_ras_push_data_i),
        .ex_stall_valid_i    (ex_stall_valid_i),
        .lk                  (lk.ctrl),
        .upd                 (upd.ctrl),
        .btb_hit_i           (btb_hit),
        .btb_target_i        (btb_target),
        .ras_top_i           (ras_top),
        .ras_valid_i         (ras_valid),
        .ras_push_o          (ras_push),
        .ras_pop_o           (ras_pop),
        .ras_push_data_o     (ras_push_data),
        .branch_or_not_o     (branch_or_not_o),
        .pdt_res_o           (pdt_res_o),
        .pdt_pc_o            (pdt_pc_o),
        .provider_o          (provider_o),
        .history_o           (history_o)
    );

    tage_tables tage_i (
        .clk (clk),
        .rst (rst),
        .lk  (lk.tables),
        .upd (upd.store)
    );

    btb btb_i (
        .clk      (clk),
        .rst      (rst),
        .pc_i     (if_pc_i),
        .hit_o    (btb_hit),
        .target_o (btb_target),
        .upd      (upd.store)
    );

    ras ras_i (
        .clk         (clk),
        .rst         (rst),
        .push_i      (ras_push),
        .pop_i       (ras_pop),
        .push_data_i (ras_push_data),
        .top_o       (ras_top),
        .valid_o     (ras_valid)
    );

endmodule

/* source/bpu_ctrl.sv */
`timescale 1ns/1ns
`include "bpu_macros.svh"

module bpu_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  bpu_pkg::addr_t     if_pc_i,
    input  bpu_pkg::inst_t     if_inst_i,
    input  logic               ex_branch_valid_i,
    input  logic               ex_branch_taken_i,
    input  logic               ex_pdt_true_i,
    input  bpu_pkg::addr_t     ex_pc_i,
    input  bpu_pkg::ghist_t    ex_history_i,
    input  bpu_pkg::provider_t ex_provider_i,
    input  bpu_pkg::addr_t     ex_target_i,
    input  bpu_pkg::inst_t     ex_inst_i,
    input  logic               id_ras_push_valid_i,
    input  bpu_pkg::addr_t     id_ras_push_data_i,
    input  logic               ex_stall_valid_i,
    lookup_if.ctrl             lk,
    update_if.ctrl             upd,
    input  logic               btb_hit_i,
    input  bpu_pkg::addr_t     btb_target_i,
    input  bpu_pkg::addr_t     ras_top_i,
    input  logic               ras_valid_i,
    output logic               ras_push_o,
    output logic               ras_pop_o,
    output bpu_pkg::addr_t     ras_push_data_o,
    output logic               branch_or_not_o,
    output logic               pdt_res_o,
    output bpu_pkg::addr_t     pdt_pc_o,
    output bpu_pkg::provider_t provider_o,
    output bpu_pkg::ghist_t    history_o
);

    bpu_pkg::ghist_t ghist;
    bpu_pkg::addr_t  pc_plus4;
    bpu_pkg::addr_t  b_imm;
    bpu_pkg::addr_t  j_imm;
    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic            is_ret;
    logic            ex_is_ret;

    // fetch side decode
    assign is_branch = (if_inst_i[6:0] == `OPC_BRANCH);
    assign is_jal    = (if_inst_i[6:0] == `OPC_JAL);
    assign is_jalr   = (if_inst_i[6:0] == `OPC_JALR);
    assign is_ret    = is_jalr && (if_inst_i[11:7] == 5'd0)
                       && ((if_inst_i[19:15] == 5'd1) || (if_inst_i[19:15] == 5'd5))
                       && (if_inst_i[31:20] == 12'd0);

    // execute side only needs jalr through ra or t0
    assign ex_is_ret = (ex_inst_i[6:0] == `OPC_JALR)
                       && ((ex_inst_i[19:15] == 5'd1) || (ex_inst_i[19:15] == 5'd5));

    assign pc_plus4 = if_pc_i + bpu_pkg::addr_t'(4);
    assign b_imm    = {{20{if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25],
                       if_inst_i[11:8], 1'b0};
    assign j_imm    = {{12{if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20],
                       if_inst_i[30:21], 1'b0};

    assign lk.pc      = if_pc_i;
    assign lk.history = ghist;

    always_comb begin
        branch_or_not_o = 1'b0;
        pdt_res_o       = 1'b0;
        pdt_pc_o        = pc_plus4;
        if (is_ret) begin
            branch_or_not_o = 1'b1;
            if (ras_valid_i) begin      // empty stack falls through to pc+4
                pdt_res_o = 1'b1;
                pdt_pc_o  = ras_top_i;
            end
        end else if (is_jal) begin
            branch_or_not_o = 1'b1;
            pdt_res_o       = 1'b1;
            pdt_pc_o        = btb_hit_i ? btb_target_i : if_pc_i + j_imm;
        end else if (is_branch || is_jalr) begin
            branch_or_not_o = 1'b1;
            pdt_res_o       = lk.taken;
            if (lk.taken) begin
                if (btb_hit_i)
                    pdt_pc_o = btb_target_i;
                else if (is_branch)
                    pdt_pc_o = if_pc_i + b_imm;
            end
        end
    end

    assign provider_o = lk.provider;
    assign history_o  = ghist;

    // feedback straight into the tables
    assign upd.valid    = ex_branch_valid_i;
    assign upd.taken    = ex_branch_taken_i;
    assign upd.correct  = ex_pdt_true_i;
    assign upd.pc       = ex_pc_i;
    assign upd.history  = ex_history_i;
    assign upd.provider = ex_provider_i;
    assign upd.target   = ex_target_i;

    // stall blocks both stack operations
    assign ras_pop_o       = ex_branch_valid_i && ex_branch_taken_i && ex_is_ret
                             && !ex_stall_valid_i;
    assign ras_push_o      = id_ras_push_valid_i && !ex_stall_valid_i;
    assign ras_push_data_o = id_ras_push_data_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ghist <= '0;
        end else if (ex_branch_valid_i) begin
            ghist <= {ghist[`GHIST_W-2:0], ex_branch_taken_i};  // newest at bit 0
        end
    end

endmodule

/* source/bpu_if.sv */
`timescale 1ns/1ns

// combinational direction lookup between control and the tables
interface lookup_if;
    bpu_pkg::addr_t     pc;
    bpu_pkg::ghist_t    history;
    logic               taken;      // provider counter msb
    bpu_pkg::provider_t provider;

    modport ctrl (
        output pc, history,
        input  taken, provider
    );

    modport tables (
        input  pc, history,
        output taken, provider
    );
endinterface

// execute feedback, acted on at the edge where valid is high
interface update_if;
    logic               valid;
    logic               taken;
    logic               correct;    // prediction matched the outcome
    bpu_pkg::addr_t     pc;
    bpu_pkg::ghist_t    history;    // history seen at prediction time
    bpu_pkg::provider_t provider;   // provider reported at prediction time
    bpu_pkg::addr_t     target;

    modport ctrl (
        output valid, taken, correct, pc, history, provider, target
    );

    modport store (
        input  valid, taken, correct, pc, history, provider, target
    );
endinterface

/* source/bpu_macros.svh */
`ifndef BPU_MACROS_SVH
`define BPU_MACROS_SVH

// datapath widths
`define XLEN              32
`define GHIST_W           16

// predictor table geometry
`define BIMODAL_ENTRIES   512
`define TAGE_ENTRIES      256     // per tagged table
`define TAG_W             10
`define PARTIAL_TAG_BITS  6       // upper tag bits compared on lookup

`define BTB_ENTRIES       256
`define BTB_TAG_W         22

`define RAS_DEPTH         32
`define RAS_PTR_W         6       // one extra bit so a full stack fits

// rv32 opcodes of interest
`define OPC_BRANCH        7'b1100011
`define OPC_JAL           7'b1101111
`define OPC_JALR          7'b1100111

// which table supplied the direction
`define PROV_BIMODAL      2'd0
`define PROV_T0           2'd1
`define PROV_T1           2'd2

`define CTR_INIT          2'b01   // weak not-taken

`endif

/* source/bpu_pkg.sv */
`include "bpu_macros.svh"

package bpu_pkg;

    // fetch and target addresses
    typedef logic [`XLEN-1:0]      addr_t;
    typedef logic [`XLEN-1:0]      inst_t;

    // global branch history, newest outcome in bit 0
    typedef logic [`GHIST_W-1:0]   ghist_t;

    typedef logic [`TAG_W-1:0]     tag_t;      // tagged table tag
    typedef logic [`BTB_TAG_W-1:0] btb_tag_t;

    // 2-bit saturating counter, msb is the direction
    typedef logic [1:0]            ctr_t;

    typedef logic [1:0]            provider_t; // PROV_* codes

    typedef logic [`RAS_PTR_W-1:0] ras_ptr_t;

endpackage

/* source/btb.sv */
`timescale 1ns/1ns
`include "bpu_macros.svh"

module btb (
    input  logic           clk,
    input  logic           rst,
    input  bpu_pkg::addr_t pc_i,
    output logic           hit_o,
    output bpu_pkg::addr_t target_o,
    update_if.store        upd
);

    logic              entry_valid [`BTB_ENTRIES];
    bpu_pkg::btb_tag_t entry_tag   [`BTB_ENTRIES];
    bpu_pkg::addr_t    entry_tgt   [`BTB_ENTRIES];

    logic [7:0]        rd_idx;
    logic [7:0]        wr_idx;
    logic              wr_en;

    // word aligned index, remaining upper bits as tag
    assign rd_idx = pc_i[9:2];
    assign wr_idx = upd.pc[9:2];
    assign wr_en  = upd.valid && upd.taken;   // only taken branches allocate

    assign hit_o    = entry_valid[rd_idx] && (entry_tag[rd_idx] == pc_i[31:10]);
    assign target_o = entry_tgt[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BTB_ENTRIES; i++)
                entry_valid[i] <= 1'b0;
        end else if (wr_en) begin
            entry_valid[wr_idx] <= 1'b1;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (wr_en) begin
            entry_tag[wr_idx] <= upd.pc[31:10];
            entry_tgt[wr_idx] <= upd.target;
        end
    end

endmodule

/* source/ras.sv */
`timescale 1ns/1ns
`include "bpu_macros.svh"

module ras (
    input  logic           clk,
    input  logic           rst,
    input  logic           push_i,
    input  logic           pop_i,
    input  bpu_pkg::addr_t push_data_i,
    output bpu_pkg::addr_t top_o,
    output logic           valid_o
);

    bpu_pkg::addr_t   stack [`RAS_DEPTH];
    bpu_pkg::ras_ptr_t sp;              // next free slot
    bpu_pkg::ras_ptr_t sp_popped;
    bpu_pkg::ras_ptr_t top_ptr;
    logic             do_push;

    // pop first, ignored when empty
    always_comb begin
        sp_popped = sp;
        if (pop_i && (sp != '0))
            sp_popped = sp - 1'b1;
    end

    // then push, dropped when full
    assign do_push = push_i && (sp_popped != bpu_pkg::ras_ptr_t'(`RAS_DEPTH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            sp <= '0;
        else
            sp <= do_push ? sp_popped + 1'b1 : sp_popped;
    end

    always_ff @(posedge clk) begin
        if (do_push)
            stack[sp_popped[`RAS_PTR_W-2:0]] <= push_data_i;
    end

    assign top_ptr = sp - 1'b1;
    assign top_o   = stack[top_ptr[`RAS_PTR_W-2:0]];  // stale when empty
    assign valid_o = (sp != '0);

endmodule

/* source/tage_tables.sv */
`timescale 1ns/1ns
`include "bpu_macros.svh"

module tage_tables (
    input  logic     clk,
    input  logic     rst,
    lookup_if.tables lk,
    update_if.store  upd
);

    bpu_pkg::ctr_t bim_ctr [`BIMODAL_ENTRIES];
    bpu_pkg::tag_t t0_tag  [`TAGE_ENTRIES];
    bpu_pkg::ctr_t t0_ctr  [`TAGE_ENTRIES];
    bpu_pkg::tag_t t1_tag  [`TAGE_ENTRIES];
    bpu_pkg::ctr_t t1_ctr  [`TAGE_ENTRIES];

    logic [8:0]    l_bim_idx;
    logic [7:0]    l_t0_idx;
    logic [7:0]    l_t1_idx;
    bpu_pkg::tag_t l_t0_tag;
    bpu_pkg::tag_t l_t1_tag;
    logic          t0_hit;
    logic          t1_hit;

    logic [8:0]    u_bim_idx;
    logic [7:0]    u_t0_idx;
    logic [7:0]    u_t1_idx;
    bpu_pkg::tag_t u_t0_tag;
    bpu_pkg::tag_t u_t1_tag;

    // shared hashes for lookup and update
    function automatic logic [7:0] t0_index(input bpu_pkg::addr_t pc,
                                            input bpu_pkg::ghist_t h);
        return pc[7:0] ^ h[7:0];
    endfunction

    function automatic logic [7:0] t1_index(input bpu_pkg::addr_t pc,
                                            input bpu_pkg::ghist_t h);
        return pc[7:0] ^ h[15:8];
    endfunction

    function automatic bpu_pkg::tag_t t0_tag_of(input bpu_pkg::addr_t pc,
                                                input bpu_pkg::ghist_t h);
        return pc[17:8] ^ h[15:6];
    endfunction

    function automatic bpu_pkg::tag_t t1_tag_of(input bpu_pkg::addr_t pc,
                                                input bpu_pkg::ghist_t h);
        return pc[17:8] ^ {2'b00, h[7:0]};
    endfunction

    function automatic bpu_pkg::ctr_t sat(input bpu_pkg::ctr_t c, input logic up);
        if (up)
            return (c == 2'b11) ? c : c + 2'b01;
        return (c == 2'b00) ? c : c - 2'b01;
    endfunction

    // lookup
    assign l_bim_idx = lk.pc[9:1];
    assign l_t0_idx  = t0_index(lk.pc, lk.history);
    assign l_t1_idx  = t1_index(lk.pc, lk.history);
    assign l_t0_tag  = t0_tag_of(lk.pc, lk.history);
    assign l_t1_tag  = t1_tag_of(lk.pc, lk.history);

    // partial match on the upper tag bits only
    assign t0_hit = t0_tag[l_t0_idx][`TAG_W-1:`TAG_W-`PARTIAL_TAG_BITS]
                    == l_t0_tag[`TAG_W-1:`TAG_W-`PARTIAL_TAG_BITS];
    assign t1_hit = t1_tag[l_t1_idx][`TAG_W-1:`TAG_W-`PARTIAL_TAG_BITS]
                    == l_t1_tag[`TAG_W-1:`TAG_W-`PARTIAL_TAG_BITS];

    always_comb begin
        if (t1_hit) begin           // longest history wins
            lk.provider = `PROV_T1;
            lk.taken    = t1_ctr[l_t1_idx][1];
        end else if (t0_hit) begin
            lk.provider = `PROV_T0;
            lk.taken    = t0_ctr[l_t0_idx][1];
        end else begin
            lk.provider = `PROV_BIMODAL;
            lk.taken    = bim_ctr[l_bim_idx][1];
        end
    end

    // update side, indexed with the history carried back from execute
    assign u_bim_idx = upd.pc[9:1];
    assign u_t0_idx  = t0_index(upd.pc, upd.history);
    assign u_t1_idx  = t1_index(upd.pc, upd.history);
    assign u_t0_tag  = t0_tag_of(upd.pc, upd.history);
    assign u_t1_tag  = t1_tag_of(upd.pc, upd.history);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BIMODAL_ENTRIES; i++)
                bim_ctr[i] <= `CTR_INIT;
            for (int i = 0; i < `TAGE_ENTRIES; i++) begin
                t0_tag[i] <= '0;
                t0_ctr[i] <= `CTR_INIT;
                t1_tag[i] <= '0;
                t1_ctr[i] <= `CTR_INIT;
            end
        end else if (upd.valid) begin
            bim_ctr[u_bim_idx] <= sat(bim_ctr[u_bim_idx], upd.taken);
            if (upd.correct) begin
                case (upd.provider)
                    `PROV_T1: t1_ctr[u_t1_idx] <= sat(t1_ctr[u_t1_idx], upd.taken);
                    `PROV_T0: t0_ctr[u_t0_idx] <= sat(t0_ctr[u_t0_idx], upd.taken);
                    default: ;
                endcase
            end else begin
                case (upd.provider)
                    `PROV_T1: t1_ctr[u_t1_idx] <= {upd.taken, upd.taken};  // strong
                    `PROV_T0: t0_ctr[u_t0_idx] <= {upd.taken, upd.taken};
                    `PROV_BIMODAL: begin
                        // allocate, T1 first, counter weak toward the outcome
                        if (t1_tag[u_t1_idx] != u_t1_tag) begin
                            t1_tag[u_t1_idx] <= u_t1_tag;
                            t1_ctr[u_t1_idx] <= {upd.taken, ~upd.taken};
                        end else if (t0_tag[u_t0_idx] != u_t0_tag) begin
                            t0_tag[u_t0_idx] <= u_t0_tag;
                            t0_ctr[u_t0_idx] <= {upd.taken, ~upd.taken};
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

/* tests/bpu_tb.sv */
`timescale 1ns/1ns
`include "bpu_macros.svh"

module bpu_tb;

    localparam int settle_ns      = 20;    // well before the next rising edge
    localparam int stim_cycles    = 100;   // rough length of all five tests
    localparam int timeout_cycles = 4 * stim_cycles;

    localparam bpu_pkg::inst_t ret_ra = 32'h0000_8067;  // jalr x0, 0(ra)
    localparam bpu_pkg::inst_t ret_t0 = 32'h0002_8067;  // jalr x0, 0(t0)

    logic               clk;
    logic               rst;
    bpu_pkg::addr_t     if_pc;
    bpu_pkg::inst_t     if_inst;
    logic               ex_branch_valid;
    logic               ex_branch_taken;
    logic               ex_pdt_true;
    bpu_pkg::addr_t     ex_pc;
    bpu_pkg::ghist_t    ex_history;
    bpu_pkg::provider_t ex_provider;
    bpu_pkg::addr_t     ex_target;
    bpu_pkg::inst_t     ex_inst;
    logic               id_ras_push_valid;
    bpu_pkg::addr_t     id_ras_push_data;
    logic               ex_stall_valid;

    logic               branch_or_not;
    logic               pdt_res;
    bpu_pkg::addr_t     pdt_pc;
    bpu_pkg::ghist_t    history;
    bpu_pkg::provider_t provider;

    bpu_pkg::ghist_t    hist_model;        // expected global history
    integer             seed = 32'h1bcb;
    int                 checks;
    int                 errors;
    int                 chk_mark;
    int                 err_mark;

    tb_clock clock_i (.clk_o(clk));

    bpu bpu_i (
        .clk                 (clk),
        .rst                 (rst),
        .if_pc_i             (if_pc),
        .if_inst_i           (if_inst),
        .ex_branch_valid_i   (ex_branch_valid),
        .ex_branch_taken_i   (ex_branch_taken),
        .ex_pdt_true_i       (ex_pdt_true),
        .ex_pc_i             (ex_pc),
        .ex_history_i        (ex_history),
        .ex_provider_i       (ex_provider),
        .ex_target_i         (ex_target),
        .ex_inst_i           (ex_inst),
        .id_ras_push_valid_i (id_ras_push_valid),
        .id_ras_push_data_i  (id_ras_push_data),
        .ex_stall_valid_i    (ex_stall_valid),
        .branch_or_not_o     (branch_or_not),
        .pdt_res_o           (pdt_res),
        .pdt_pc_o            (pdt_pc),
        .history_o           (history),
        .provider_o          (provider)
    );

    function automatic bpu_pkg::ghist_t shift_hist(input bpu_pkg::ghist_t h, input logic taken);
        return {h[`GHIST_W-2:0], taken};   // newest outcome enters at bit 0
    endfunction

    function automatic bpu_pkg::inst_t encode_jal(input bpu_pkg::addr_t imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, `OPC_JAL};
    endfunction

    // beq x1, x2, imm
    function automatic bpu_pkg::inst_t encode_branch(input bpu_pkg::addr_t imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    // would either tagged table match a tag still at its reset value
    function automatic logic zero_tag_hit(input bpu_pkg::addr_t pc, input bpu_pkg::ghist_t h);
        bpu_pkg::tag_t t0;
        bpu_pkg::tag_t t1;
        t0 = pc[17:8] ^ h[15:6];
        t1 = pc[17:8] ^ {2'b00, h[7:0]};
        return (t0[`TAG_W-1:`TAG_W-`PARTIAL_TAG_BITS] == '0)
               || (t1[`TAG_W-1:`TAG_W-`PARTIAL_TAG_BITS] == '0);
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic expect_pred(input logic br, input logic taken, input bpu_pkg::addr_t target);
        check_eq(branch_or_not, br, "branch_or_not_o");
        check_eq(pdt_res, taken, "pdt_res_o");
        check_eq(pdt_pc, target, "pdt_pc_o");
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
        chk_mark = checks;
        err_mark = errors;
    endtask

    task automatic init_inputs();
        rst               = 1'b1;
        if_pc             = '0;
        if_inst           = '0;
        ex_branch_valid   = 1'b0;
        ex_branch_taken   = 1'b0;
        ex_pdt_true       = 1'b0;
        ex_pc             = '0;
        ex_history        = '0;
        ex_provider       = `PROV_BIMODAL;
        ex_target         = '0;
        ex_inst           = '0;
        id_ras_push_valid = 1'b0;
        id_ras_push_data  = '0;
        ex_stall_valid    = 1'b0;
        hist_model        = '0;
    endtask

    task automatic lookup(input bpu_pkg::addr_t pc, input bpu_pkg::inst_t inst);
        @(negedge clk);
        if_pc   = pc;
        if_inst = inst;
        #(settle_ns);
    endtask

    // one execute strobe with the history compared against the model afterwards
    task automatic feedback(input bpu_pkg::addr_t pc, input logic taken, input logic correct,
                            input bpu_pkg::provider_t prov, input bpu_pkg::ghist_t hist,
                            input bpu_pkg::addr_t target, input bpu_pkg::inst_t inst);
        @(negedge clk);
        ex_branch_valid = 1'b1;
        ex_branch_taken = taken;
        ex_pdt_true     = correct;
        ex_pc           = pc;
        ex_history      = hist;
        ex_provider     = prov;
        ex_target       = target;
        ex_inst         = inst;
        @(negedge clk);
        ex_branch_valid = 1'b0;
        ex_inst         = '0;
        hist_model      = shift_hist(hist_model, taken);
        #(settle_ns);
        check_eq(history, hist_model, "history_o");
    endtask

    task automatic push_ras(input bpu_pkg::addr_t data, input logic stall);
        @(negedge clk);
        id_ras_push_valid = 1'b1;
        id_ras_push_data  = data;
        ex_stall_valid    = stall;
        @(negedge clk);
        id_ras_push_valid = 1'b0;
        ex_stall_valid    = 1'b0;
    endtask

    task automatic test_defaults();
        bpu_pkg::addr_t pc;
        bpu_pkg::inst_t inst;
        logic [31:0]    rnd;
        check_eq(history, '0, "history_o after reset");
        repeat (20) begin
            pc      = $random(seed);
            pc[1:0] = 2'b00;
            inst    = $random(seed);
            if (inst[6:0] == `OPC_BRANCH || inst[6:0] == `OPC_JAL || inst[6:0] == `OPC_JALR)
                inst[6:0] = 7'b0010011;     // make it op-imm
            lookup(pc, inst);
            expect_pred(1'b0, 1'b0, pc + 32'd4);
        end
        repeat (8) begin
            rnd = $random(seed);
            feedback(32'h0000_0100, rnd[0], 1'b1, `PROV_BIMODAL, hist_model,
                     32'h0000_0200, encode_branch(32'h0000_0100));
        end
        end_test("reset and defaults");
    endtask

    task automatic test_jal();
        bpu_pkg::addr_t pc;
        bpu_pkg::addr_t imm;
        bpu_pkg::addr_t target;
        bpu_pkg::inst_t inst;
        pc     = 32'h0002_0400;
        imm    = 32'hffff_f800;     // -2048
        target = 32'h0000_9000;
        inst   = encode_jal(imm);
        lookup(pc, inst);
        expect_pred(1'b1, 1'b1, pc + imm);
        feedback(pc, 1'b1, 1'b1, `PROV_BIMODAL, hist_model, target, inst);
        lookup(pc, inst);
        expect_pred(1'b1, 1'b1, target);   // now from the btb
        end_test("jal");
    endtask

    task automatic test_bimodal();
        bpu_pkg::addr_t  pc;
        bpu_pkg::addr_t  target;
        bpu_pkg::inst_t  inst;
        bpu_pkg::ghist_t h1;
        bpu_pkg::ghist_t h2;
        int              k;
        inst   = encode_branch(32'h0000_0040);
        target = 32'h0000_5550;
        h1     = shift_hist(hist_model, 1'b1);
        h2     = shift_hist(h1, 1'b1);
        pc     = 32'h0000_00c8;
        k      = 0;
        // step pc[17:12] until no tagged table matches before or after training
        while (k < 63 && (zero_tag_hit(pc, hist_model) || zero_tag_hit(pc, h1)
                          || zero_tag_hit(pc, h2))) begin
            k++;
            pc[17:12] = k[5:0];
        end
        lookup(pc, inst);
        check_eq(provider, `PROV_BIMODAL, "provider_o");
        expect_pred(1'b1, 1'b0, pc + 32'd4);
        feedback(pc, 1'b1, 1'b1, `PROV_BIMODAL, hist_model, target, inst);
        feedback(pc, 1'b1, 1'b1, `PROV_BIMODAL, hist_model, target, inst);
        lookup(pc, inst);
        check_eq(provider, `PROV_BIMODAL, "provider_o");
        expect_pred(1'b1, 1'b1, target);
        // same bimodal entry but another btb tag so the b-immediate gives the target
        lookup(pc + 32'h0000_0400, inst);
        expect_pred(1'b1, 1'b1, pc + 32'h0000_0440);
        end_test("bimodal training");
    endtask

    task automatic test_tagged();
        bpu_pkg::addr_t  pc;
        bpu_pkg::addr_t  pc_bim;
        bpu_pkg::ghist_t h_look;
        bpu_pkg::inst_t  inst;
        int              k;
        inst   = encode_branch(32'h0000_0080);
        // history seen by the lookup after two taken and one not-taken strobe
        h_look = shift_hist(shift_hist(shift_hist(hist_model, 1'b1), 1'b1), 1'b0);
        pc     = 32'h0000_01a4;
        pc[17:12] = {2'b00, h_look[7:4]};   // partial T1 tag equals the reset tag
        feedback(pc, 1'b1, 1'b1, `PROV_BIMODAL, hist_model, 32'h0000_6000, inst);
        feedback(pc, 1'b1, 1'b1, `PROV_BIMODAL, hist_model, 32'h0000_6000, inst);
        feedback(pc, 1'b0, 1'b0, `PROV_T1, h_look, pc + 32'd4, inst);
        lookup(pc, inst);
        check_eq(provider, `PROV_T1, "provider_o");
        expect_pred(1'b1, 1'b0, pc + 32'd4);   // bimodal alone would say taken
        // same bimodal entry with both partial tags missing
        pc_bim = pc;
        k      = 0;
        while (k < 63 && zero_tag_hit(pc_bim, h_look)) begin
            k++;
            pc_bim[17:12] = k[5:0];
        end
        lookup(pc_bim, inst);
        check_eq(provider, `PROV_BIMODAL, "provider_o");
        expect_pred(1'b1, 1'b1, pc_bim + 32'h0000_0080);
        end_test("tagged override");
    endtask

    task automatic test_ras();
        bpu_pkg::addr_t pc;
        bpu_pkg::addr_t ret_a;
        bpu_pkg::addr_t ret_b;
        pc    = 32'h0000_0300;
        ret_a = 32'h0000_1104;
        ret_b = 32'h0000_2208;
        lookup(pc, ret_ra);
        expect_pred(1'b1, 1'b0, pc + 32'd4);   // empty stack
        push_ras(ret_a, 1'b0);
        push_ras(ret_b, 1'b0);
        lookup(pc, ret_ra);
        expect_pred(1'b1, 1'b1, ret_b);
        // executed taken return pops
        feedback(pc, 1'b1, 1'b1, `PROV_BIMODAL, hist_model, ret_b, ret_ra);
        lookup(pc, ret_t0);
        expect_pred(1'b1, 1'b1, ret_a);
        push_ras(32'h0000_3330, 1'b1);         // lost to the stall
        lookup(pc, ret_ra);
        expect_pred(1'b1, 1'b1, ret_a);
        end_test("return address stack");
    endtask

    initial begin
        init_inputs();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        test_defaults();
        test_jal();
        test_bimodal();
        test_tagged();
        test_ras();
        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the tests did not finish", timeout_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* tests/tb_clock.sv */
`timescale 1ns/1ns

// free running testbench clock, 100 ns period
module tb_clock (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

endmodule
